/* project.f */
+incdir+hdl
hdl/atu_pkg.sv
hdl/ms_tick.sv
hdl/atu_sequencer.sv
hdl/atu_regs.sv
hdl/atu_ctrl_top.sv
verification/tb_clock.sv
verification/atu_ctrl_tb.sv

/* verification/atu_ctrl_tb.sv */
// ATU controller testbench, random ATU responder from a fixed seed
// Runs with prescale 3, so one tick is 4 clocks after the first reload
`timescale 1ns/1ps
`include "atu_params.svh"

module atu_ctrl_tb;

  localparam int P             = 4;   // Tick period in clocks
  localparam int NUM_SEQ       = 40;
  localparam int MAX_SEQ_TICKS = 68;  // 4 limits of up to 13 ticks, plus bus and gaps
  localparam int WATCHDOG_CLKS = `ATU_PS_DEFAULT + 1 + NUM_SEQ * MAX_SEQ_TICKS * P + 2000;

  logic clk, rst_n, cyc, stb, we, ack, auto_tune, atu_status, mox_in, atu_start, mox_out;
  logic [2:0]  adr;
  logic [31:0] dat_w, dat_r;
  logic [3:0]  sel;
  logic [7:0]  cyc_cnt = '0;        // Drives the mox_in pattern
  logic        hold_possible = 1'b0; // From expected HOLD entry until the drop settles
  integer      seed = 76030;
  int          errors = 0;

  tb_clock u_clk (.clk(clk), .rst_n(rst_n));

  atu_ctrl_top dut0 (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack), .auto_tune(auto_tune),
    .atu_status(atu_status), .mox_in(mox_in), .atu_start(atu_start), .mox_out(mox_out)
  );

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;  // 0 .. n-1
  endfunction

  // Reference model of how an attempt ends, per responder mode
  function automatic logic [1:0] expected_result(input int unsigned mode);
    case (mode)
      0:       return atu_pkg::RES_NO_RESPONSE;  // Silent ATU
      1:       return atu_pkg::RES_TUNED;        // Busy, then done in time
      default: return atu_pkg::RES_BUSY_TIMEOUT; // Busy forever
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  // ------------------------------------------------------------
  // Wishbone classic single access, ack expected one clock after request
  // ------------------------------------------------------------
  task automatic bus_access(input logic w, input logic [2:0] a, input logic [31:0] wd,
                            output logic [31:0] rd);
    int n;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= w;
    adr   <= a;
    dat_w <= wd;
    sel   <= 4'hf;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < 8);
    assert (ack && n == 2) else begin
      errors++;
      $display("Error at %0t: bus ack missing or late at address %0d", $time, a);
    end
    rd = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    assert (!ack) else begin
      errors++;
      $display("Error at %0t: bus ack held for more than one cycle", $time);
    end
  endtask

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1'b1;
    mox_in  <= cyc_cnt[1] ^ cyc_cnt[3];  // Irregular transmit request
  end

  // mox_out must follow mox_in whenever HOLD is out of reach
  always @(negedge clk) begin
    if (rst_n && !hold_possible)
      assert (mox_out === mox_in) else begin
        errors++;
        $display("Error at %0t: mox_out expected %0b, got %0b", $time, mox_in, mox_out);
      end
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] lim [5];
    int unsigned mode, d, b, n, w, cut, busy, hold_t;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = '0;
    dat_w      = '0;
    sel        = '0;
    auto_tune  = 1'b0;
    atu_status = 1'b0;
    mox_in     = 1'b0;
    @(posedge rst_n);
    // ------------------------------------------------------------
    // Register defaults, STATUS, holes, then the test timing
    // ------------------------------------------------------------
    bus_access(1'b1, `ATU_ADDR_STATUS, 32'hffff_ffff, rd);  // Must be dropped
    bus_access(1'b1, 3'd6, 32'hffff_ffff, rd);
    bus_access(1'b1, 3'd7, 32'hffff_ffff, rd);
    lim = '{`ATU_PS_DEFAULT, `ATU_TUNE_DELAY_DEFAULT, `ATU_TUNE_WIDTH_DEFAULT,
            `ATU_LDETECT_DEFAULT, `ATU_HDETECT_DEFAULT};
    for (int a = 0; a < 5; a++) begin
      bus_access(1'b0, a, '0, rd);
      check_val($sformatf("reg %0d default", a), lim[a], rd);
    end
    bus_access(1'b0, `ATU_ADDR_STATUS, '0, rd);
    check_val("STATUS", 32'h0, rd);
    bus_access(1'b0, 3'd6, '0, rd);
    check_val("reg 6", 32'h0, rd);
    bus_access(1'b0, 3'd7, '0, rd);
    check_val("reg 7", 32'h0, rd);
    lim[0] = P - 1;
    for (int a = 1; a < 5; a++) lim[a] = 2 + rnd(11);  // 2 .. 12
    for (int a = 0; a < 5; a++) bus_access(1'b1, a, lim[a], rd);
    for (int a = 0; a < 5; a++) begin
      bus_access(1'b0, a, '0, rd);
      check_val($sformatf("reg %0d", a), lim[a], rd);
    end
    repeat (`ATU_PS_DEFAULT + 1) @(posedge clk);  // Old count drains, new prescale reloads
    // ------------------------------------------------------------
    // Tune sequences, lim[1..4] are delay, width, ldetect, hdetect
    // ------------------------------------------------------------
    for (int s = 0; s < NUM_SEQ; s++) begin
      mode = rnd(4);                 // 3 aborts at a random point
      d    = rnd(lim[3]);            // Busy delay in ticks, inside the window
      b    = 1 + rnd(lim[4]);        // Busy length in ticks
      busy = rnd(2);                 // Abort case only, ATU busy from the start
      // Abort lands no later than the tick that would enter HOLD
      cut  = 1 + rnd((busy ? lim[1] + lim[2] + lim[4] + 4
                           : lim[1] + lim[2] + lim[3] + 3) * P - 1);
      @(posedge clk);
      auto_tune <= 1'b1;
      if (mode == 3) begin
        atu_status <= (busy != 0);
        repeat (cut) @(posedge clk);
      end else begin
        n = 0;
        do begin
          @(negedge clk);
          n++;
        end while (!atu_start && n < (lim[1] + 4) * P);
        assert (atu_start && n - 1 >= (lim[1] + 1) * P && n - 1 <= (lim[1] + 2) * P) else begin
          errors++;
          $display("Error at %0t: atu_start delay expected %0d to %0d clocks, got %0d",
                   $time, (lim[1] + 1) * P, (lim[1] + 2) * P, n - 1);
        end
        w = 0;
        while (atu_start && w < (lim[2] + 3) * P) begin
          w++;
          @(negedge clk);
        end
        check_val("atu_start width", (lim[2] + 1) * P, w);
        case (mode)  // Ticks from the pulse end to HOLD
          0:       hold_t = lim[3] + 1;
          1:       hold_t = d + 1 + b;
          default: hold_t = d + lim[4] + 2;
        endcase
        fork
          begin  // ATU responder, times counted from the pulse end
            if (mode != 0) begin
              repeat (d * P + 1) @(posedge clk);
              atu_status <= 1'b1;
              if (mode == 1) begin
                repeat (b * P) @(posedge clk);
                atu_status <= 1'b0;
              end
            end
          end
          begin  // Poll STATUS until HOLD
            n = 0;
            do begin
              bus_access(1'b0, `ATU_ADDR_STATUS, '0, rd);
              n++;
            end while (rd[2:0] != atu_pkg::ST_HOLD && n < 100);
          end
          begin  // Gate may close from the HOLD entry edge on
            repeat (hold_t * P) @(posedge clk);
            hold_possible = 1'b1;
          end
        join
        check_val("STATUS state", atu_pkg::ST_HOLD, rd[2:0]);
        check_val("STATUS result", expected_result(mode), rd[5:4]);
        n = 0;
        do begin
          @(negedge clk);
          n++;
        end while (!mox_in && n < 16);
        check_val("mox_out in HOLD", 1'b0, mox_out);
      end
      @(posedge clk);
      auto_tune  <= 1'b0;
      atu_status <= 1'b0;
      repeat (P) @(posedge clk);  // One tick period to reach IDLE
      hold_possible = 1'b0;
      bus_access(1'b0, `ATU_ADDR_STATUS, '0, rd);
      check_val("STATUS state after drop", atu_pkg::ST_IDLE, rd[2:0]);
      check_val("STATUS result after drop", atu_pkg::RES_NONE, rd[5:4]);
      check_val("atu_start after drop", 1'b0, atu_start);
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CLKS * 100);
    $display("Timeout: the sequences did not complete within %0d clocks", WATCHDOG_CLKS);
    $display("Errors: %0d", errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset source, 100 ns period
// rst_n is held low for the first 5 rising edges
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 10 MHz
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;  // Released on a rising edge
  end

endmodule

/* hdl/atu_ctrl_top.sv */
// ATU controller top, register block, tick prescaler and sequencer
// Tick period is (prescale+1) clocks, set over Wishbone
`timescale 1ns/1ps
`include "atu_params.svh"

module atu_ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  // Wishbone slave
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`ATU_ADDR_BITS-1:0] adr,
  input  logic [`ATU_DATA_BITS-1:0] dat_w,
  input  logic [3:0]                sel,
  output logic [`ATU_DATA_BITS-1:0] dat_r,
  output logic                      ack,
  // Radio and ATU side
  input  logic                      auto_tune,
  input  logic                      atu_status,
  input  logic                      mox_in,
  output logic                      atu_start,
  output logic                      mox_out
);

  atu_pkg::atu_timing_t    timing;    // Limits to the sequencer
  atu_pkg::atu_status_t    status;    // Sequencer state back to the bus
  logic [`ATU_PS_BITS-1:0] prescale;
  logic                    tick;

  // ----------------------------------------------------------
  atu_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack),
    .status(status), .timing(timing), .prescale(prescale)
  );

  ms_tick u_tick (
    .clk(clk), .rst_n(rst_n), .prescale(prescale), .tick(tick)
  );

  atu_sequencer u_seq (
    .clk(clk), .rst_n(rst_n), .tick(tick),
    .auto_tune(auto_tune), .atu_status(atu_status), .mox_in(mox_in),
    .timing(timing), .atu_start(atu_start), .mox_out(mox_out),
    .status(status)
  );

endmodule

/* hdl/atu_regs.sv */
// Wishbone classic slave with the timing registers and a status readback
// One wait state, ack for one clock, no stall and no err
// Writes to STATUS or undefined addresses are dropped, undefined reads give zero
`timescale 1ns/1ps
`include "atu_params.svh"

module atu_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`ATU_ADDR_BITS-1:0] adr,
  input  logic [`ATU_DATA_BITS-1:0] dat_w,
  input  logic [3:0]                sel,
  output logic [`ATU_DATA_BITS-1:0] dat_r,
  output logic                      ack,
  input  atu_pkg::atu_status_t      status,
  output atu_pkg::atu_timing_t      timing,
  output logic [`ATU_PS_BITS-1:0]   prescale
);

  logic [`ATU_DATA_BITS-1:0] rd_word;    // Addressed register, zero extended
  logic [`ATU_DATA_BITS-1:0] wr_merged;  // rd_word with enabled bytes replaced

  wire req = cyc & stb & ~ack;  // New request, ack not yet given

  // Byte enable merge
  function automatic logic [`ATU_DATA_BITS-1:0] byte_merge(
    input logic [`ATU_DATA_BITS-1:0] cur,
    input logic [`ATU_DATA_BITS-1:0] wdat,
    input logic [3:0]                be
  );
    logic [`ATU_DATA_BITS-1:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = wdat[8*i +: 8];
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // Read mux, also the base for partial writes
  // ----------------------------------------------------------
  always_comb begin
    rd_word = '0;
    case (adr)
      `ATU_ADDR_PRESCALE:   rd_word[`ATU_PS_BITS-1:0]  = prescale;
      `ATU_ADDR_TUNE_DELAY: rd_word[`ATU_TMR_BITS-1:0] = timing.tune_delay;
      `ATU_ADDR_TUNE_WIDTH: rd_word[`ATU_TMR_BITS-1:0] = timing.tune_width;
      `ATU_ADDR_LDETECT:    rd_word[`ATU_TMR_BITS-1:0] = timing.ldetect_limit;
      `ATU_ADDR_HDETECT:    rd_word[`ATU_TMR_BITS-1:0] = timing.hdetect_limit;
      `ATU_ADDR_STATUS: begin
        rd_word[2:0]   = status.state;   // Bit 3 reads zero
        rd_word[5:4]   = status.result;
        rd_word[31:16] = status.timer;
      end
      default: rd_word = '0;
    endcase
  end

  assign wr_merged = byte_merge(rd_word, dat_w, sel);

  // ----------------------------------------------------------
  // Registers, write lands on the edge that raises ack
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack                  <= 1'b0;
      prescale             <= `ATU_PS_DEFAULT;
      timing.tune_delay    <= `ATU_TUNE_DELAY_DEFAULT;
      timing.tune_width    <= `ATU_TUNE_WIDTH_DEFAULT;
      timing.ldetect_limit <= `ATU_LDETECT_DEFAULT;
      timing.hdetect_limit <= `ATU_HDETECT_DEFAULT;
    end else begin
      ack <= req;
      if (req && we) begin
        case (adr)
          `ATU_ADDR_PRESCALE:   prescale             <= wr_merged[`ATU_PS_BITS-1:0];
          `ATU_ADDR_TUNE_DELAY: timing.tune_delay    <= wr_merged[`ATU_TMR_BITS-1:0];
          `ATU_ADDR_TUNE_WIDTH: timing.tune_width    <= wr_merged[`ATU_TMR_BITS-1:0];
          `ATU_ADDR_LDETECT:    timing.ldetect_limit <= wr_merged[`ATU_TMR_BITS-1:0];
          `ATU_ADDR_HDETECT:    timing.hdetect_limit <= wr_merged[`ATU_TMR_BITS-1:0];
          default: ;  // STATUS and holes ignore writes
        endcase
      end
    end
  end

  // Read data, held while ack is high
  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_word;
  end

  // Single clock ack per request
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack);

endmodule

/* hdl/atu_sequencer.sv */
// AH-4 style tune sequencer, advances only on tick clocks
// atu_status is used as is, no debounce, no retry after a failed attempt
// Limits are sampled when the timer loads
`timescale 1ns/1ps
`include "atu_params.svh"

module atu_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tick,
  input  logic                auto_tune,
  input  logic                atu_status,
  input  logic                mox_in,
  input  atu_pkg::atu_timing_t timing,
  output logic                atu_start,
  output logic                mox_out,
  output atu_pkg::atu_status_t status
);

  atu_pkg::atu_state_t      state;
  atu_pkg::atu_result_t     result;
  logic [`ATU_TMR_BITS-1:0] timer;        // Shared by all timed states
  logic                     tune;         // Start pulse register
  logic                     mox_inhibit;  // Set on entry to HOLD

  wire timer_zero = (timer == '0);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= atu_pkg::ST_IDLE;
      result      <= atu_pkg::RES_NONE;
      timer       <= '0;
      tune        <= 1'b0;
      mox_inhibit <= 1'b0;
    end else if (tick) begin
      if (!auto_tune) begin
        // Radio dropped the request, abort from any state
        state       <= atu_pkg::ST_IDLE;
        result      <= atu_pkg::RES_NONE;
        tune        <= 1'b0;
        mox_inhibit <= 1'b0;
      end else begin
        case (state)
          atu_pkg::ST_IDLE: begin
            state <= atu_pkg::ST_DELAY;
            timer <= timing.tune_delay;
          end
          atu_pkg::ST_DELAY: begin
            if (timer_zero) begin
              state <= atu_pkg::ST_PULSE;
              timer <= timing.tune_width;
              tune  <= 1'b1;  // Start pulse begins
            end else begin
              timer <= timer - 1'b1;
            end
          end
          atu_pkg::ST_PULSE: begin
            if (timer_zero) begin
              state <= atu_pkg::ST_WAIT_BUSY;
              timer <= timing.ldetect_limit;
              tune  <= 1'b0;
            end else begin
              timer <= timer - 1'b1;
            end
          end
          atu_pkg::ST_WAIT_BUSY: begin
            if (timer_zero) begin
              state       <= atu_pkg::ST_HOLD;  // ATU never answered
              result      <= atu_pkg::RES_NO_RESPONSE;
              mox_inhibit <= 1'b1;
            end else if (atu_status) begin
              state <= atu_pkg::ST_WAIT_DONE;
              timer <= timing.hdetect_limit;
            end else begin
              timer <= timer - 1'b1;
            end
          end
          atu_pkg::ST_WAIT_DONE: begin
            // Expiry wins over a status drop on the same tick
            if (timer_zero) begin
              state       <= atu_pkg::ST_HOLD;
              result      <= atu_pkg::RES_BUSY_TIMEOUT;
              mox_inhibit <= 1'b1;
            end else if (!atu_status) begin
              state       <= atu_pkg::ST_HOLD;
              result      <= atu_pkg::RES_TUNED;
              mox_inhibit <= 1'b1;
            end else begin
              timer <= timer - 1'b1;
            end
          end
          atu_pkg::ST_HOLD: ;  // Stay until auto_tune drops
          default: state <= atu_pkg::ST_IDLE;
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  assign atu_start     = tune;
  assign mox_out       = mox_in & ~mox_inhibit;
  assign status.state  = state;
  assign status.result = result;
  assign status.timer  = timer;

  // Pulse only while in PULSE
  a_start_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    tune |-> state == atu_pkg::ST_PULSE);
  // Transmit blocked only in HOLD
  a_inhibit_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mox_inhibit |-> state == atu_pkg::ST_HOLD);
  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {atu_pkg::ST_IDLE, atu_pkg::ST_DELAY, atu_pkg::ST_PULSE,
                  atu_pkg::ST_WAIT_BUSY, atu_pkg::ST_WAIT_DONE, atu_pkg::ST_HOLD});

endmodule

/* hdl/ms_tick.sv */
// Tick generator, one clock high every prescale+1 clocks
// A new prescale value takes effect at the next reload
`timescale 1ns/1ps
`include "atu_params.svh"

module ms_tick (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`ATU_PS_BITS-1:0] prescale,
  output logic                    tick
);

  logic [`ATU_PS_BITS-1:0] cnt;  // Down counter

  // ----------------------------------------------------------
  // Counter starts at zero so the first tick follows reset
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= prescale;  // Reload picks up register changes
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

/* hdl/atu_pkg.sv */
// Types shared by the ATU sequencer and its register block
// Field widths follow atu_params.svh
`include "atu_params.svh"

package atu_pkg;

  // ----------------------------------------------------------
  // Sequencer state
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,  // auto_tune low
    ST_DELAY     = 3'd1,  // Wait before the start pulse
    ST_PULSE     = 3'd2,  // atu_start high
    ST_WAIT_BUSY = 3'd3,  // Wait for ATU to report busy
    ST_WAIT_DONE = 3'd4,  // Wait for ATU to finish
    ST_HOLD      = 3'd5   // Result latched, mox blocked
  } atu_state_t;

  // How the last attempt ended
  typedef enum logic [1:0] {
    RES_NONE         = 2'd0,
    RES_TUNED        = 2'd1,
    RES_NO_RESPONSE  = 2'd2,  // Never went busy
    RES_BUSY_TIMEOUT = 2'd3   // Busy too long
  } atu_result_t;

  // ----------------------------------------------------------
  // Register to sequencer bundles
  // ----------------------------------------------------------
  typedef struct packed {
    logic [`ATU_TMR_BITS-1:0] tune_delay;     // Ticks before the pulse, minus one
    logic [`ATU_TMR_BITS-1:0] tune_width;     // Pulse length, minus one
    logic [`ATU_TMR_BITS-1:0] ldetect_limit;  // Busy detect window
    logic [`ATU_TMR_BITS-1:0] hdetect_limit;  // Max busy time
  } atu_timing_t;

  typedef struct packed {
    atu_state_t               state;
    atu_result_t              result;
    logic [`ATU_TMR_BITS-1:0] timer;          // Live timer value
  } atu_status_t;

endpackage

/* hdl/atu_params.svh */
// Default timing and register map for the ATU controller
// Limits count ticks minus one, defaults assume a 76.8 MHz clock and 1 ms tick
`ifndef ATU_PARAMS_SVH
`define ATU_PARAMS_SVH

// Widths
`define ATU_PS_BITS             17      // Prescale count, 1 ms at 76.8 MHz
`define ATU_TMR_BITS            16      // Sequencer timer and each limit
`define ATU_ADDR_BITS           3       // Word address
`define ATU_DATA_BITS           32      // Bus data

// Reset values
`define ATU_PS_DEFAULT          17'd76799  // 1 ms
`define ATU_TUNE_DELAY_DEFAULT  16'd99     // 100 ms
`define ATU_TUNE_WIDTH_DEFAULT  16'd499    // 500 ms
`define ATU_LDETECT_DEFAULT     16'd999    // 1 s
`define ATU_HDETECT_DEFAULT     16'd8999   // 9 s

// Word addresses
`define ATU_ADDR_PRESCALE       3'd0
`define ATU_ADDR_TUNE_DELAY     3'd1
`define ATU_ADDR_TUNE_WIDTH     3'd2
`define ATU_ADDR_LDETECT        3'd3
`define ATU_ADDR_HDETECT        3'd4
`define ATU_ADDR_STATUS         3'd5

`endif
